/* Makefile */
# Verilator build and run of the memory island testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_island
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing -Wno-fatal

FAIL_MSG := *** TEST FAILED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST) \
		> $(LOG) 2>&1 || (cat $(LOG); exit 1)
	./$(OBJ_DIR)/V$(TOP) >> $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q -F '$(FAIL_MSG)' $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/mem_island_pkg.sv */
// Memory island shared widths, address field constants and request/response structs
package mem_island_pkg;

    // --------------------
    // Widths
    // --------------------

    // Byte address width on both ports
    localparam int unsigned AddrWidth = 32;

    // Narrow port and bank data path
    localparam int unsigned NarrowWidth     = 32;
    localparam int unsigned NarrowStrbWidth = NarrowWidth / 8;

    // Wide port data path
    localparam int unsigned WideWidth     = 64;
    localparam int unsigned WideStrbWidth = WideWidth / 8;

    // Banks covered by one wide word
    localparam int unsigned NarrowPerWide = WideWidth / NarrowWidth;

    // --------------------
    // Address fields
    // --------------------

    // Byte offset inside a narrow word
    localparam int unsigned NarrowOffBits = $clog2(NarrowStrbWidth);
    // Byte offset inside a wide word
    localparam int unsigned WideOffBits   = $clog2(WideStrbWidth);

    // In-bank word index carried to the banks
    // Banks keep only the low bits they need
    localparam int unsigned MaxWordAddrWidth = 16;

    // --------------------
    // Port structs
    // --------------------

    // Narrow request, never stalled
    typedef struct packed {
        logic                       valid;
        logic                       write;
        logic [AddrWidth-1:0]       addr;
        logic [NarrowWidth-1:0]     wdata;
        logic [NarrowStrbWidth-1:0] strb;
    } narrow_req_t;

    // Narrow read response, one cycle after the request
    typedef struct packed {
        logic                   rvalid;
        logic [NarrowWidth-1:0] rdata;
    } narrow_rsp_t;

    // Wide request, held until accepted
    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic [AddrWidth-1:0]     addr;
        logic [WideWidth-1:0]     wdata;
        logic [WideStrbWidth-1:0] strb;
    } wide_req_t;

    // Wide read response, halves merged from two banks
    typedef struct packed {
        logic                 rvalid;
        logic [WideWidth-1:0] rdata;
    } wide_rsp_t;

    // --------------------
    // Bank side
    // --------------------

    // Single bank access, word index already decoded
    typedef struct packed {
        logic                        en;
        logic                        we;
        logic [MaxWordAddrWidth-1:0] word;
        logic [NarrowWidth-1:0]      wdata;
        logic [NarrowStrbWidth-1:0]  strb;
    } bank_req_t;

endpackage

/* hw/bank_arbiter.sv */
// Bank arbiter giving narrow requests priority and accepting a wide access only when conflict free
`timescale 1ns/1ps

module bank_arbiter #(
    parameter int unsigned NumBanks = 4
) (
    input  mem_island_pkg::bank_req_t [NumBanks-1:0] nreq_bank_i,
    input  logic [NumBanks-1:0]                      nhit_i,
    input  mem_island_pkg::bank_req_t [NumBanks-1:0] wreq_bank_i,
    output mem_island_pkg::bank_req_t [NumBanks-1:0] bank_req_o,
    output logic                                     wide_ready_o
);

    // Banks where both ports want access this cycle
    logic [NumBanks-1:0] clash;

    // --------------------
    // Wide acceptance
    // --------------------

    always_comb begin
        for (int i = 0; i < NumBanks; i++) begin
            clash[i] = wreq_bank_i[i].en && nhit_i[i];
        end
    end

    // One clash in the group blocks both halves
    // so a wide access never splits across cycles
    assign wide_ready_o = ~|clash;

    // --------------------
    // Per-bank select
    // --------------------

    always_comb begin
        for (int i = 0; i < NumBanks; i++) begin
            if (nhit_i[i]) begin
                // Narrow always wins its bank
                bank_req_o[i] = nreq_bank_i[i];
            end else if (wide_ready_o) begin
                bank_req_o[i] = wreq_bank_i[i];
            end else begin
                // Stalled wide half stays off the bank
                bank_req_o[i] = '0;
            end
        end
    end

endmodule

/* hw/mem_island_top.sv */
// Memory island top level joining the narrow router, wide splitter, arbiter and SRAM banks
`timescale 1ns/1ps

module mem_island_top #(
    parameter int unsigned NumBanks     = 4,
    parameter int unsigned WordsPerBank = 64
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,

    // Narrow port, no ready
    input  mem_island_pkg::narrow_req_t narrow_req_i,
    output mem_island_pkg::narrow_rsp_t narrow_rsp_o,

    // Wide port with valid/ready handshake
    input  mem_island_pkg::wide_req_t   wide_req_i,
    output logic                        wide_ready_o,
    output mem_island_pkg::wide_rsp_t   wide_rsp_o
);

    // Decoded narrow traffic per bank
    mem_island_pkg::bank_req_t [NumBanks-1:0] nreq_bank;
    logic [NumBanks-1:0]                      nhit;

    // Split wide traffic per bank
    mem_island_pkg::bank_req_t [NumBanks-1:0] wreq_bank;

    // Arbitrated bank requests
    mem_island_pkg::bank_req_t [NumBanks-1:0] bank_req;

    // Read data of every bank, seen by both ports
    logic [NumBanks-1:0][mem_island_pkg::NarrowWidth-1:0] bank_rdata;

    // --------------------
    // Request decoding
    // --------------------

    narrow_router #(
        .NumBanks(NumBanks)
    ) u_narrow_router (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .narrow_req_i(narrow_req_i),
        .nreq_bank_o (nreq_bank),
        .nhit_o      (nhit),
        .bank_rdata_i(bank_rdata),
        .narrow_rsp_o(narrow_rsp_o)
    );

    // Ready fed back so only accepted reads are tracked
    wide_splitter #(
        .NumBanks(NumBanks)
    ) u_wide_splitter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .wide_req_i  (wide_req_i),
        .wide_ready_i(wide_ready_o),
        .wreq_bank_o (wreq_bank),
        .bank_rdata_i(bank_rdata),
        .wide_rsp_o  (wide_rsp_o)
    );

    // --------------------
    // Arbitration
    // --------------------

    bank_arbiter #(
        .NumBanks(NumBanks)
    ) u_bank_arbiter (
        .nreq_bank_i (nreq_bank),
        .nhit_i      (nhit),
        .wreq_bank_i (wreq_bank),
        .bank_req_o  (bank_req),
        .wide_ready_o(wide_ready_o)
    );

    // --------------------
    // Banks
    // --------------------

    for (genvar b = 0; b < NumBanks; b++) begin : gen_banks
        sram_bank #(
            .WordsPerBank(WordsPerBank)
        ) u_bank (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .bank_req_i(bank_req[b]),
            .rdata_o   (bank_rdata[b])
        );
    end

endmodule

/* hw/sram_bank.sv */
// Single-port SRAM bank with byte write enables and one-cycle registered read
`timescale 1ns/1ps

module sram_bank #(
    parameter int unsigned WordsPerBank = 64
) (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    input  mem_island_pkg::bank_req_t             bank_req_i,
    output logic [mem_island_pkg::NarrowWidth-1:0] rdata_o
);

    localparam int unsigned WordBits = $clog2(WordsPerBank);
    localparam int unsigned ByteW    =
        mem_island_pkg::NarrowWidth / mem_island_pkg::NarrowStrbWidth;

    // Storage array
    logic [mem_island_pkg::NarrowWidth-1:0] mem_q [WordsPerBank];
    logic [mem_island_pkg::NarrowWidth-1:0] rdata_q;
    logic [WordBits-1:0]                    word_idx;

    // Upper index bits beyond the bank depth are ignored
    assign word_idx = bank_req_i.word[WordBits-1:0];

    // Byte-wise write
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < mem_island_pkg::NarrowStrbWidth; b++) begin
            if (bank_req_i.en && bank_req_i.we && bank_req_i.strb[b]) begin
                mem_q[word_idx][b*ByteW +: ByteW] <= bank_req_i.wdata[b*ByteW +: ByteW];
            end
        end
    end

    // Read port, data held until the next read
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (bank_req_i.en && !bank_req_i.we) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* tests/tb_mem_island.sv */
// Memory island testbench running a vector table on both ports against a byte-level memory model
`timescale 1ns/1ps

module tb_mem_island;

    localparam int ClkPeriod = 100;
    localparam int NumVecs   = 19;
    // Default geometry of 4 banks by 64 words by 4 bytes
    localparam int MemBytes  = 4 * 64 * 4;

    // One table entry
    // conc adds a narrow read in the same cycle
    typedef struct packed {
        logic        wide;
        logic        write;
        logic [31:0] addr;
        logic [63:0] data;
        logic [7:0]  strb;
        logic        conc;
        logic [31:0] conc_addr;
        logic        stall;
    } vec_t;

    logic                        clk_i;
    logic                        arst_n_i;
    mem_island_pkg::narrow_req_t narrow_req_i;
    mem_island_pkg::narrow_rsp_t narrow_rsp_o;
    mem_island_pkg::wide_req_t   wide_req_i;
    logic                        wide_ready_o;
    mem_island_pkg::wide_rsp_t   wide_rsp_o;

    vec_t        vecs [NumVecs];
    int          num_added;
    logic [7:0]  model_mem [MemBytes];
    logic [31:0] lcg_state;

    // Responses due at the next falling edge
    logic        exp_n_valid;
    logic [31:0] exp_n_data;
    logic        exp_w_valid;
    logic [63:0] exp_w_data;

    mem_island_top dut0 (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .narrow_req_i(narrow_req_i),
        .narrow_rsp_o(narrow_rsp_o),
        .wide_req_i  (wide_req_i),
        .wide_ready_o(wide_ready_o),
        .wide_rsp_o  (wide_rsp_o)
    );

    initial clk_i = 1'b0;
    always #(ClkPeriod / 2) clk_i = ~clk_i;

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Both ports share one flat byte space
    function automatic logic [63:0] model_read(input logic [31:0] addr, input int nbytes);
        int          base;
        logic [63:0] val;
        base = int'(addr % MemBytes) & ~(nbytes - 1);
        val  = '0;
        for (int b = 0; b < nbytes; b++) begin
            val[b*8 +: 8] = model_mem[base + b];
        end
        return val;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [63:0] data,
                               input logic [7:0] strb, input int nbytes);
        int base;
        base = int'(addr % MemBytes) & ~(nbytes - 1);
        for (int b = 0; b < nbytes; b++) begin
            if (strb[b]) begin
                model_mem[base + b] = data[b*8 +: 8];
            end
        end
    endtask

    // Narrow side accepted at this edge
    task automatic commit_narrow();
        if (narrow_req_i.write) begin
            model_write(narrow_req_i.addr, {32'h0, narrow_req_i.wdata},
                        {4'h0, narrow_req_i.strb}, 4);
        end else begin
            exp_n_valid = 1'b1;
            exp_n_data  = 32'(model_read(narrow_req_i.addr, 4));
        end
    endtask

    // Wide side accepted at this edge
    task automatic commit_wide();
        if (wide_req_i.write) begin
            model_write(wide_req_i.addr, wide_req_i.wdata, wide_req_i.strb, 8);
        end else begin
            exp_w_valid = 1'b1;
            exp_w_data  = model_read(wide_req_i.addr, 8);
        end
    endtask

    // Every falling edge compares rvalid and compares data only when a read is due
    task automatic check_responses();
        check_value("narrow_rsp_o.rvalid", narrow_rsp_o.rvalid, exp_n_valid);
        if (exp_n_valid) begin
            check_value("narrow_rsp_o.rdata", narrow_rsp_o.rdata, exp_n_data);
        end
        check_value("wide_rsp_o.rvalid", wide_rsp_o.rvalid, exp_w_valid);
        if (exp_w_valid) begin
            check_value("wide_rsp_o.rdata", wide_rsp_o.rdata, exp_w_data);
        end
        exp_n_valid = 1'b0;
        exp_w_valid = 1'b0;
    endtask

    task automatic add_vec(input logic wide, input logic write, input logic [31:0] addr,
                           input logic [7:0] strb, input logic conc,
                           input logic [31:0] conc_addr, input logic stall);
        vec_t v;
        v.wide      = wide;
        v.write     = write;
        v.addr      = addr;
        v.data      = {next_rand(), next_rand()};
        v.strb      = strb;
        v.conc      = conc;
        v.conc_addr = conc_addr;
        v.stall     = stall;
        if (num_added < NumVecs) begin
            vecs[num_added] = v;
        end
        num_added++;
    endtask

    // --------------------
    // Vector table
    // --------------------

    // Wide 0x018 is group 1 word 1
    // Wide 0x020 is group 0 word 2
    task automatic build_table();
        // Narrow read-back
        add_vec(1'b0, 1'b1, 32'h000, 8'h0f, 1'b0, 32'h0, 1'b0);
        add_vec(1'b0, 1'b0, 32'h000, 8'h00, 1'b0, 32'h0, 1'b0);
        // Wide write seen through banks 2 and 3
        add_vec(1'b1, 1'b1, 32'h018, 8'hff, 1'b0, 32'h0, 1'b0);
        add_vec(1'b0, 1'b0, 32'h018, 8'h00, 1'b0, 32'h0, 1'b0);
        add_vec(1'b0, 1'b0, 32'h01c, 8'h00, 1'b0, 32'h0, 1'b0);
        // Partial narrow write then wide read
        add_vec(1'b0, 1'b1, 32'h01c, 8'h05, 1'b0, 32'h0, 1'b0);
        add_vec(1'b1, 1'b0, 32'h018, 8'h00, 1'b0, 32'h0, 1'b0);
        add_vec(1'b1, 1'b1, 32'h020, 8'hff, 1'b0, 32'h0, 1'b0);
        // Same group clash then different groups
        add_vec(1'b1, 1'b0, 32'h020, 8'h00, 1'b1, 32'h000, 1'b1);
        add_vec(1'b1, 1'b0, 32'h018, 8'h00, 1'b1, 32'h000, 1'b0);
        add_vec(1'b1, 1'b1, 32'h038, 8'hff, 1'b0, 32'h0, 1'b0);
        // Back-to-back wide reads on alternating groups
        add_vec(1'b1, 1'b0, 32'h020, 8'h00, 1'b0, 32'h0, 1'b0);
        add_vec(1'b1, 1'b0, 32'h038, 8'h00, 1'b0, 32'h0, 1'b0);
        add_vec(1'b1, 1'b0, 32'h020, 8'h00, 1'b0, 32'h0, 1'b0);
        add_vec(1'b1, 1'b0, 32'h018, 8'h00, 1'b0, 32'h0, 1'b0);
        add_vec(1'b0, 1'b1, 32'h024, 8'h0a, 1'b0, 32'h0, 1'b0);
        add_vec(1'b1, 1'b0, 32'h020, 8'h00, 1'b1, 32'h018, 1'b0);
        // Narrow on the upper bank stalls a low half wide write
        add_vec(1'b1, 1'b1, 32'h020, 8'h0f, 1'b1, 32'h024, 1'b1);
        add_vec(1'b1, 1'b0, 32'h020, 8'h00, 1'b0, 32'h0, 1'b0);
    endtask

    // Called on a falling edge and returns on the falling edge after the response
    task automatic apply_vec(input vec_t v);
        logic wide_done;
        narrow_req_i = '0;
        wide_req_i   = '0;
        if (v.wide) begin
            wide_req_i.valid = 1'b1;
            wide_req_i.write = v.write;
            wide_req_i.addr  = v.addr;
            wide_req_i.wdata = v.data;
            wide_req_i.strb  = v.strb;
            if (v.conc) begin
                narrow_req_i.valid = 1'b1;
                narrow_req_i.addr  = v.conc_addr;
            end
        end else begin
            narrow_req_i.valid = 1'b1;
            narrow_req_i.write = v.write;
            narrow_req_i.addr  = v.addr;
            narrow_req_i.wdata = v.data[31:0];
            narrow_req_i.strb  = v.strb[3:0];
        end
        // Ready is stable at the accepting edge since the falling edge
        @(posedge clk_i);
        wide_done = !v.wide;
        if (v.wide) begin
            check_value("wide_ready_o", wide_ready_o, !v.stall);
        end
        if (narrow_req_i.valid) begin
            commit_narrow();
        end
        if (v.wide && wide_ready_o) begin
            commit_wide();
            wide_done = 1'b1;
        end
        // Narrow drops after one cycle while wide holds until taken
        while (!wide_done) begin
            @(negedge clk_i);
            check_responses();
            narrow_req_i = '0;
            @(posedge clk_i);
            if (wide_ready_o) begin
                commit_wide();
                wide_done = 1'b1;
            end
        end
        @(negedge clk_i);
        check_responses();
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        arst_n_i     = 1'b0;
        narrow_req_i = '0;
        wide_req_i   = '0;
        lcg_state    = 32'haace;
        num_added    = 0;
        exp_n_valid  = 1'b0;
        exp_n_data   = '0;
        exp_w_valid  = 1'b0;
        exp_w_data   = '0;
        build_table();
        if (num_added != NumVecs) begin
            $display("Vector table holds %0d entries but %0d were added", NumVecs, num_added);
            $display("*** TEST FAILED ***");
            $fatal(1, "vector table size");
        end
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        // Idle after reset
        @(negedge clk_i);
        check_value("narrow_rsp_o.rvalid", narrow_rsp_o.rvalid, 1'b0);
        check_value("wide_rsp_o.rvalid", wide_rsp_o.rvalid, 1'b0);
        check_value("wide_ready_o", wide_ready_o, 1'b1);
        for (int i = 0; i < NumVecs; i++) begin
            apply_vec(vecs[i]);
        end
        narrow_req_i = '0;
        wide_req_i   = '0;
        @(negedge clk_i);
        check_responses();
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #((NumVecs * 20 + 50) * ClkPeriod);
        $display("Timeout: run did not complete within %0d clock periods", NumVecs * 20 + 50);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* vlog.f */
common/mem_island_pkg.sv
hw/sram_bank.sv
hw/bank_arbiter.sv
xbar/narrow_router.sv
xbar/wide_splitter.sv
hw/mem_island_top.sv
tests/tb_mem_island.sv

/* xbar/narrow_router.sv */
// Narrow router decoding the narrow address to one bank and returning that bank's read data
`timescale 1ns/1ps

module narrow_router #(
    parameter int unsigned NumBanks = 4
) (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  mem_island_pkg::narrow_req_t                          narrow_req_i,
    output mem_island_pkg::bank_req_t [NumBanks-1:0]             nreq_bank_o,
    output logic [NumBanks-1:0]                                  nhit_o,
    input  logic [NumBanks-1:0][mem_island_pkg::NarrowWidth-1:0] bank_rdata_i,
    output mem_island_pkg::narrow_rsp_t                          narrow_rsp_o
);

    // Address layout: word index, bank, byte offset
    localparam int unsigned BankBits = $clog2(NumBanks);
    localparam int unsigned WordLsb  = mem_island_pkg::NarrowOffBits + BankBits;

    logic [BankBits-1:0]                         bank_sel;
    logic [mem_island_pkg::MaxWordAddrWidth-1:0] word_idx;

    // Read tracking for the response cycle
    logic [BankBits-1:0] rd_bank_q;
    logic                rd_valid_q;

    // --------------------
    // Decode
    // --------------------

    assign bank_sel = narrow_req_i.addr[mem_island_pkg::NarrowOffBits +: BankBits];
    assign word_idx = narrow_req_i.addr[WordLsb +: mem_island_pkg::MaxWordAddrWidth];

    // Only the selected bank sees the request
    always_comb begin
        for (int i = 0; i < NumBanks; i++) begin
            nhit_o[i]      = narrow_req_i.valid && (bank_sel == BankBits'(i));
            nreq_bank_o[i] = '0;
            if (nhit_o[i]) begin
                nreq_bank_o[i].en    = 1'b1;
                nreq_bank_o[i].we    = narrow_req_i.write;
                nreq_bank_o[i].word  = word_idx;
                nreq_bank_o[i].wdata = narrow_req_i.wdata;
                nreq_bank_o[i].strb  = narrow_req_i.strb;
            end
        end
    end

    // --------------------
    // Response
    // --------------------

    // Narrow never stalls, so every valid read is served
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_q <= 1'b0;
            rd_bank_q  <= '0;
        end else begin
            rd_valid_q <= narrow_req_i.valid && !narrow_req_i.write;
            rd_bank_q  <= bank_sel;
        end
    end

    // Bank output register holds the word in this cycle
    assign narrow_rsp_o.rvalid = rd_valid_q;
    assign narrow_rsp_o.rdata  = bank_rdata_i[rd_bank_q];

endmodule

/* xbar/wide_splitter.sv */
// Wide splitter mapping a wide access onto a bank pair and merging the two read halves
`timescale 1ns/1ps

module wide_splitter #(
    parameter int unsigned NumBanks = 4
) (
    input  logic                                                 clk_i,
    input  logic                                                 arst_n_i,
    input  mem_island_pkg::wide_req_t                            wide_req_i,
    input  logic                                                 wide_ready_i,
    output mem_island_pkg::bank_req_t [NumBanks-1:0]             wreq_bank_o,
    input  logic [NumBanks-1:0][mem_island_pkg::NarrowWidth-1:0] bank_rdata_i,
    output mem_island_pkg::wide_rsp_t                            wide_rsp_o
);

    // Group geometry
    localparam int unsigned NumGroups = NumBanks / mem_island_pkg::NarrowPerWide;
    localparam int unsigned GroupBits = $clog2(NumGroups);
    // Keep one index bit even with a single group
    localparam int unsigned GroupW    = (GroupBits > 0) ? GroupBits : 1;
    localparam int unsigned WordLsb   = mem_island_pkg::WideOffBits + GroupBits;

    // Half widths on the bank side
    localparam int unsigned HalfW     = mem_island_pkg::NarrowWidth;
    localparam int unsigned HalfStrbW = mem_island_pkg::NarrowStrbWidth;

    logic [mem_island_pkg::AddrWidth-1:0]        grp_field;
    logic [GroupW-1:0]                           group_sel;
    logic [mem_island_pkg::MaxWordAddrWidth-1:0] word_idx;

    // Read tracking for the response cycle
    logic [GroupW-1:0] rd_group_q;
    logic              rd_valid_q;

    // --------------------
    // Decode and split
    // --------------------

    // Group field sits right above the wide byte offset
    assign grp_field = wide_req_i.addr >> mem_island_pkg::WideOffBits;
    assign group_sel = GroupW'(grp_field % NumGroups);
    assign word_idx  = wide_req_i.addr[WordLsb +: mem_island_pkg::MaxWordAddrWidth];

    // Bank 2g takes the low half, bank 2g+1 the high half
    always_comb begin
        for (int i = 0; i < NumBanks; i++) begin
            wreq_bank_o[i] = '0;
            if (wide_req_i.valid &&
                (group_sel == GroupW'(i / mem_island_pkg::NarrowPerWide))) begin
                wreq_bank_o[i].en    = 1'b1;
                wreq_bank_o[i].we    = wide_req_i.write;
                wreq_bank_o[i].word  = word_idx;
                wreq_bank_o[i].wdata =
                    wide_req_i.wdata[(i % mem_island_pkg::NarrowPerWide)*HalfW +: HalfW];
                wreq_bank_o[i].strb  =
                    wide_req_i.strb[(i % mem_island_pkg::NarrowPerWide)*HalfStrbW +: HalfStrbW];
            end
        end
    end

    // --------------------
    // Response merge
    // --------------------

    // Only reads taken by the arbiter produce a response
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_q <= 1'b0;
            rd_group_q <= '0;
        end else begin
            rd_valid_q <= wide_req_i.valid && wide_ready_i && !wide_req_i.write;
            rd_group_q <= group_sel;
        end
    end

    assign wide_rsp_o.rvalid = rd_valid_q;

    // Upper bank of the pair lands in the upper half
    always_comb begin
        for (int h = 0; h < mem_island_pkg::NarrowPerWide; h++) begin
            wide_rsp_o.rdata[h*HalfW +: HalfW] =
                bank_rdata_i[rd_group_q * mem_island_pkg::NarrowPerWide + h];
        end
    end

endmodule
